//--- build.f
hdl/xdom_pkg.sv
hdl/axi_channel_xdomain.sv
hdl/cmd_arbiter.sv
hdl/reg_bank.sv
hdl/xdom_bridge_top.sv
tests/xdom_checker.sv
tests/tb_xdom_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_xdom_bridge -o sim_xdom \
  && ./obj_dir/sim_xdom > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "=== PASS ===" sim.log && exit 0 || exit 1

//--- tests/tb_xdom_bridge.sv
`timescale 1ns/10ps

module tb_xdom_bridge import xdom_pkg::*; ();

  localparam int          NENT  = 30;             // table entries.
  localparam int          LIMIT = NENT * 60 + 100; // clka cycles before giving up.
  localparam logic [31:0] SEED  = 32'ha1e2_727b;

  logic              clka, clkb, rst_n;
  logic              req_valid_host, req_valid_debug;
  logic [CMD_W-1:0]  req_word_host, req_word_debug;
  logic              req_ready_host, req_ready_debug;
  logic              rsp_valid_host, rsp_valid_debug;
  logic [DATA_W-1:0] rsp_data_host, rsp_data_debug;
  bit                done;
  int                mismatches, other_errs;
  int                cycles;

  bit               tbl_port [NENT];  // 0 host, 1 debug.
  logic [CMD_W-1:0] tbl_word [NENT];
  bit               tbl_both [NENT];  // other port reads the same register together.

  initial clka = 1'b0;
  always #10 clka = ~clka;
  initial clkb = 1'b0;
  always #7 clkb = ~clkb;            // register side runs faster.

  xdom_bridge_top #(.NPORT(NPORT)) dut_i (.*);

  xdom_checker chk_i (.*);

  function automatic logic [CMD_W-1:0] make_write(input logic [ADDR_W-1:0] addr,
                                                 input logic [DATA_W-1:0] data);
    cmd_word_u c;
    c.wr.op   = OP_WRITE;
    c.wr.addr = addr;
    c.wr.rsvd = '0;
    c.wr.data = data;
    return c;
  endfunction

  function automatic logic [CMD_W-1:0] make_setclr(input logic [ADDR_W-1:0] addr,
                                                  input logic [7:0] set_mask,
                                                  input logic [7:0] clr_mask);
    cmd_word_u c;
    c.sc.op       = OP_SETCLR;
    c.sc.addr     = addr;
    c.sc.rsvd     = '0;
    c.sc.set_mask = set_mask;
    c.sc.clr_mask = clr_mask;
    return c;
  endfunction

  task automatic set_entry(input int k, input bit port, input logic [CMD_W-1:0] word,
                           input bit both);
    tbl_port[k] = port;
    tbl_word[k] = word;
    tbl_both[k] = both;
  endtask

  task automatic fill_table();
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 16; i++) begin  // every register gets a value tied to its address.
      set_entry(i, i[0], make_write(4'(i), 16'ha500 ^ (16'(i) * 16'h1111)), 1'b0);
    end
    set_entry(16, 1'b0, make_setclr(4'd3, 8'h00, 8'h00), 1'b0);  // plain reads.
    set_entry(17, 1'b1, make_setclr(4'd7, 8'h00, 8'h00), 1'b0);
    set_entry(18, 1'b0, make_setclr(4'd12, 8'h00, 8'h00), 1'b0);
    set_entry(19, 1'b1, make_setclr(4'd15, 8'h00, 8'h00), 1'b0);
    for (int j = 0; j < 3; j++) begin
      a = 4'($urandom);
      set_entry(20 + 2 * j, 1'b0, make_setclr(a, 8'($urandom), 8'($urandom)), 1'b0);
      set_entry(21 + 2 * j, 1'b1, make_setclr(a, 8'h00, 8'h00), 1'b0);  // read back.
    end
    set_entry(26, 1'b0, make_write(4'd9, 16'hc3a5), 1'b1);   // host wins and debug goes last.
    set_entry(27, 1'b0, make_write(4'd5, 16'h5a5a), 1'b0);   // host served last again.
    set_entry(28, 1'b1, make_write(4'd10, 16'h0ff0), 1'b1);  // so debug wins this clash.
    set_entry(29, 1'b1, make_setclr(4'd5, 8'h00, 8'h00), 1'b0);  // sees the host write.
  endtask

  // drive one entry, hold valid until ready, wait for every response.
  task automatic run_entry(input int k);
    cmd_word_u c;
    logic      pend_h, pend_d, acc_h, acc_d;
    int        need_h, need_d;
    c = tbl_word[k];
    @(posedge clka);
    #1;
    pend_h = (tbl_port[k] == 1'b0) || tbl_both[k];
    pend_d = (tbl_port[k] == 1'b1) || tbl_both[k];
    req_word_host  = tbl_port[k] ? make_setclr(c.wr.addr, 8'h00, 8'h00) : tbl_word[k];
    req_word_debug = tbl_port[k] ? tbl_word[k] : make_setclr(c.wr.addr, 8'h00, 8'h00);
    req_valid_host  = pend_h;
    req_valid_debug = pend_d;
    need_h = int'(pend_h);
    need_d = int'(pend_d);
    while (pend_h || pend_d || need_h > 0 || need_d > 0) begin
      @(negedge clka);                 // outputs settled mid cycle.
      acc_h = pend_h && req_ready_host;
      acc_d = pend_d && req_ready_debug;
      if (rsp_valid_host) need_h--;
      if (rsp_valid_debug) need_d--;
      @(posedge clka);
      #1;
      if (acc_h) begin
        req_valid_host = 1'b0;
        pend_h = 1'b0;
      end
      if (acc_d) begin
        req_valid_debug = 1'b0;
        pend_d = 1'b0;
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    req_valid_host  = 1'b0;
    req_valid_debug = 1'b0;
    req_word_host   = '0;
    req_word_debug  = '0;
    void'($urandom(SEED));
    fill_table();
    repeat (8) @(posedge clka);
    #1;
    rst_n = 1'b1;
    for (int k = 0; k < NENT; k++) run_entry(k);
    repeat (10) @(posedge clka);      // room for any stray response.
    #1;
    done = 1'b1;
    repeat (2) @(posedge clka);
    #1;
    $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog.
  initial begin
    while (!done && cycles < LIMIT) begin
      @(posedge clka);
      cycles++;
    end
    if (!done) begin
      $display("run timed out after %0d clka cycles", cycles);
      $display("errors: %0d mismatches, %0d other", mismatches, other_errs + 1);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

//--- tests/xdom_checker.sv
`timescale 1ns/10ps

// watches both requester ports of the bridge and keeps a model of the bank.
module xdom_checker import xdom_pkg::*; (
  input  logic              clka,
  input  logic              rst_n,
  input  logic              req_valid_host,
  input  logic [CMD_W-1:0]  req_word_host,
  input  logic              req_ready_host,
  input  logic              rsp_valid_host,
  input  logic [DATA_W-1:0] rsp_data_host,
  input  logic              req_valid_debug,
  input  logic [CMD_W-1:0]  req_word_debug,
  input  logic              req_ready_debug,
  input  logic              rsp_valid_debug,
  input  logic [DATA_W-1:0] rsp_data_debug,
  input  logic              done,          // stimulus finished.
  output int                mismatches,
  output int                other_errs
);

  logic [DATA_W-1:0] model [16];           // expected register contents.
  logic [CMD_W-1:0]  host_q [$];           // accepted, not yet answered.
  logic [CMD_W-1:0]  debug_q [$];
  bit                have_last;            // some port was granted already.
  bit                last_port;
  bit                reported;

  function automatic string port_name(input bit port);
    return port ? "debug" : "host";
  endfunction

  // register value after one command.
  function automatic logic [DATA_W-1:0] next_value(input logic [DATA_W-1:0] old,
                                                   input cmd_word_u c);
    logic [7:0] low;
    if (c.wr.op == OP_WRITE) return c.wr.data;  // whole word replaced.
    low = old[7:0] & ~c.sc.clr_mask;           // clear first.
    low = low | c.sc.set_mask;                 // then set.
    return {old[DATA_W-1:8], low};
  endfunction

  task automatic note_accept(input bit port, input logic [CMD_W-1:0] word,
                             input logic other_valid);
    if (port) debug_q.push_back(word);
    else host_q.push_back(word);
    // on a clash the port not served last must win.
    if (other_valid && have_last && port == last_port) begin
      $display("Mismatch at %0t: clash granted %s again, expected %s", $time,
               port_name(port), port_name(!port));
      mismatches++;
    end
    have_last = 1'b1;
    last_port = port;
  endtask

  task automatic check_response(input bit port, input logic [DATA_W-1:0] got);
    cmd_word_u         c;
    logic [DATA_W-1:0] exp;
    if ((port ? debug_q.size() : host_q.size()) == 0) begin
      $display("%0t: response on the %s port with no command waiting", $time, port_name(port));
      other_errs++;
      return;
    end
    c = port ? debug_q.pop_front() : host_q.pop_front();
    exp = next_value(model[c.wr.addr], c);
    model[c.wr.addr] = exp;  // one command in flight, so order is kept.
    if (got !== exp) begin
      $display("Mismatch at %0t: %s port reg %0d got %h, expected %h", $time,
               port_name(port), c.wr.addr, got, exp);
      mismatches++;
    end
  endtask

  always @(posedge clka) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) model[i] = '0;  // bank clears on reset.
      host_q.delete();
      debug_q.delete();
      have_last  = 1'b0;
      reported   = 1'b0;
      mismatches = 0;
      other_errs = 0;
    end else begin
      if (req_ready_host && req_ready_debug) begin
        $display("%0t: both ports were accepted on the same edge", $time);
        other_errs++;
      end
      if (req_valid_host && req_ready_host) note_accept(1'b0, req_word_host, req_valid_debug);
      if (req_valid_debug && req_ready_debug) note_accept(1'b1, req_word_debug, req_valid_host);
      if (rsp_valid_host) check_response(1'b0, rsp_data_host);
      if (rsp_valid_debug) check_response(1'b1, rsp_data_debug);
      if (done && !reported) begin
        reported = 1'b1;
        if (host_q.size() + debug_q.size() != 0) begin
          $display("%0d commands never got a response", host_q.size() + debug_q.size());
          other_errs += host_q.size() + debug_q.size();
        end
      end
    end
  end

endmodule

//--- hdl/xdom_bridge_top.sv
`timescale 1ns/10ps

module xdom_bridge_top import xdom_pkg::*; #(
  parameter int NPORT = xdom_pkg::NPORT
) (
  input  logic              clka,
  input  logic              clkb,
  input  logic              rst_n,
  input  logic              req_valid_host,
  input  logic [CMD_W-1:0]  req_word_host,
  output logic              req_ready_host,
  output logic              rsp_valid_host,
  output logic [DATA_W-1:0] rsp_data_host,
  input  logic              req_valid_debug,
  input  logic [CMD_W-1:0]  req_word_debug,
  output logic              req_ready_debug,
  output logic              rsp_valid_debug,
  output logic [DATA_W-1:0] rsp_data_debug
);

  // port 0 is host, port 1 is debug.
  logic [NPORT-1:0]            req_valid;
  logic [NPORT-1:0][CMD_W-1:0] req_word;
  logic [NPORT-1:0]            req_ready;
  logic [NPORT-1:0]            rsp_valid;
  logic [DATA_W-1:0]           rsp_data;

  logic              cmd_valid, cmd_ready;     // arbiter to command crossing.
  logic [CMD_W-1:0]  cmd_word;
  logic              cmd_valid_b, cmd_ready_b; // command crossing to bank.
  logic [CMD_W-1:0]  cmd_word_b;
  logic              rsp_valid_b, rsp_ready_b; // bank to return crossing.
  logic [DATA_W-1:0] rsp_word_b;
  logic              ret_valid, ret_ready;     // return crossing to arbiter.
  logic [DATA_W-1:0] ret_data;

  assign req_valid       = {req_valid_debug, req_valid_host};
  assign req_word        = {req_word_debug, req_word_host};
  assign req_ready_host  = req_ready[0];
  assign req_ready_debug = req_ready[1];
  assign rsp_valid_host  = rsp_valid[0];
  assign rsp_valid_debug = rsp_valid[1];
  assign rsp_data_host   = rsp_data;  // only the owner's valid pulses.
  assign rsp_data_debug  = rsp_data;

  cmd_arbiter #(.NPORT(NPORT)) arb_i (
    .clka, .rst_n, .req_valid, .req_word, .req_ready,
    .cmd_valid, .cmd_word, .cmd_ready,
    .ret_valid, .ret_data, .ret_ready, .rsp_valid, .rsp_data);

  axi_channel_xdomain #(.WIDTH(CMD_W)) cmd_xdom_i (
    .clka(clka), .rst_n(rst_n), .dataa(cmd_word), .valida(cmd_valid), .readya(cmd_ready),
    .clkb(clkb), .datab(cmd_word_b), .validb(cmd_valid_b), .readyb(cmd_ready_b));

  reg_bank bank_i (
    .clkb(clkb), .rst_n(rst_n), .cmd_valid(cmd_valid_b), .cmd_word(cmd_word_b),
    .cmd_ready(cmd_ready_b), .rsp_valid(rsp_valid_b), .rsp_word(rsp_word_b),
    .rsp_ready(rsp_ready_b));

  // return path runs the other way, so the clocks swap.
  axi_channel_xdomain #(.WIDTH(DATA_W)) ret_xdom_i (
    .clka(clkb), .rst_n(rst_n), .dataa(rsp_word_b), .valida(rsp_valid_b), .readya(rsp_ready_b),
    .clkb(clka), .datab(ret_data), .validb(ret_valid), .readyb(ret_ready));

endmodule

//--- hdl/reg_bank.sv
`timescale 1ns/10ps

module reg_bank import xdom_pkg::*; (
  input  logic              clkb,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  logic [CMD_W-1:0]  cmd_word,
  output logic              cmd_ready,
  output logic              rsp_valid,
  output logic [DATA_W-1:0] rsp_word,
  input  logic              rsp_ready
);

  localparam int NREG = 1 << ADDR_W;

  cmd_word_u         cmd;               // same bits, two readings.
  logic [DATA_W-1:0] regs [NREG];
  logic [DATA_W-1:0] cur;               // addressed register now.
  logic [DATA_W-1:0] nxt;               // its value after the command.
  logic              accept;

  assign cmd       = cmd_word;
  assign cmd_ready = ~rsp_valid;        // no new command while answering.
  assign accept    = cmd_valid & cmd_ready;
  assign cur       = regs[cmd.wr.addr]; // addr is shared by both views.

  always_comb begin
    if (cmd.wr.op == OP_WRITE) begin
      nxt = cmd.wr.data;
    end else begin
      // clear first, then set. high byte kept.
      nxt = {cur[DATA_W-1:8], (cur[7:0] & ~cmd.sc.clr_mask) | cmd.sc.set_mask};
    end
  end

  always_ff @(posedge clkb or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
      rsp_valid <= 1'b0;
    end else begin
      if (accept) begin
        regs[cmd.wr.addr] <= nxt;
        rsp_valid         <= 1'b1;  // launch the new value.
      end else if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;          // return crossing took it.
      end
    end
  end

  // response word follows the register write.
  always_ff @(posedge clkb) begin
    if (accept) rsp_word <= nxt;
  end

  // requesters must keep the spare bits clear.
  rsvd_zero: assert property (@(posedge clkb) disable iff (!rst_n)
    accept |-> (cmd.wr.rsvd == 3'b000));

endmodule

//--- hdl/cmd_arbiter.sv
`timescale 1ns/10ps

module cmd_arbiter import xdom_pkg::*; #(
  parameter int NPORT = xdom_pkg::NPORT
) (
  input  logic                        clka,
  input  logic                        rst_n,
  input  logic [NPORT-1:0]            req_valid,
  input  logic [NPORT-1:0][CMD_W-1:0] req_word,
  output logic [NPORT-1:0]            req_ready,
  output logic                        cmd_valid,
  output logic [CMD_W-1:0]            cmd_word,
  input  logic                        cmd_ready,
  input  logic                        ret_valid,
  input  logic [DATA_W-1:0]           ret_data,
  output logic                        ret_ready,
  output logic [NPORT-1:0]            rsp_valid,
  output logic [DATA_W-1:0]           rsp_data
);

  localparam int IDX_W = (NPORT > 1) ? $clog2(NPORT) : 1;

  logic             busy;    // a transaction is in flight.
  logic [NPORT-1:0] owner;   // one-hot port that owns it.
  logic [IDX_W-1:0] last_q;  // port served last.
  logic [IDX_W-1:0] pick;
  logic [NPORT-1:0] grant;
  logic             found;

  // search starts at the port after the last one served.
  always_comb begin
    int idx;
    grant = '0;
    pick  = last_q;
    found = 1'b0;
    for (int i = 1; i <= NPORT; i++) begin
      idx = (int'(last_q) + i) % NPORT;
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        pick  = IDX_W'(idx);
      end
    end
    if (!busy && found) grant[pick] = 1'b1;
  end

  assign req_ready = grant;  // accepted on this edge.

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      owner     <= '0;
      last_q    <= '0;
      cmd_valid <= 1'b0;
      ret_ready <= 1'b0;
      rsp_valid <= '0;
    end else begin
      rsp_valid <= '0;
      if (|grant) begin
        busy      <= 1'b1;
        owner     <= grant;
        last_q    <= pick;
        cmd_valid <= 1'b1;
      end else if (cmd_valid && cmd_ready) begin
        cmd_valid <= 1'b0;  // crossing has the word.
        ret_ready <= 1'b1;  // now wait for the answer.
      end else if (ret_ready && ret_valid) begin
        ret_ready <= 1'b0;
        busy      <= 1'b0;
        rsp_valid <= owner;  // single pulse to the owner only.
      end
    end
  end

  always_ff @(posedge clka) begin
    if (|grant) cmd_word <= req_word[pick];
    if (ret_ready && ret_valid) rsp_data <= ret_data;
  end

  // one port at a time, and on a clash the port served last waits.
  grant_onehot: assert property (@(posedge clka) disable iff (!rst_n)
    $onehot0(req_ready) && !((&req_valid) && req_ready[last_q]));

  // one transaction at a time across both crossings.
  no_regrant: assert property (@(posedge clka) disable iff (!rst_n)
    (|req_ready) |=> ((req_ready == '0) until (|rsp_valid)));

endmodule

//--- hdl/axi_channel_xdomain.sv
`timescale 1ns/10ps

// moves one word from clka to clkb with a four-phase level handshake.
// valid is held on the source side until the destination has taken the word,
// and the acknowledge comes back through its own synchronizer.
module axi_channel_xdomain #(
  parameter int WIDTH = 16
) (
  input  logic             clka,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] dataa,
  input  logic             valida,
  output logic             readya,
  input  logic             clkb,
  output logic [WIDTH-1:0] datab,
  output logic             validb,
  input  logic             readyb
);

  localparam int DEPTH = 2;  // synchronizer stages.

  logic [DEPTH-1:0] xa_ack;    // b_ack seen in clka.
  logic             a_ack_q;   // for the rising edge of the ack.
  logic             a_valid;   // stretched source valid.
  logic [WIDTH-1:0] a_data;    // held while a_valid is up.
  logic             a_ack;
  logic             a_load;

  logic [DEPTH-1:0] xb_valid;  // a_valid seen in clkb.
  logic             b_valid;
  logic             b_ack;     // masks validb until the source drops.
  logic [WIDTH-1:0] b_data;
  logic             b_take;

  assign a_ack  = xa_ack[DEPTH-1];
  // only start a new word once the last handshake has fully closed.
  assign a_load = valida & ~a_valid & ~a_ack;
  assign readya = a_ack & ~a_ack_q;  // one pulse per delivered word.

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      xa_ack  <= '0;
      a_ack_q <= 1'b0;
      a_valid <= 1'b0;
    end else begin
      xa_ack  <= {xa_ack[DEPTH-2:0], b_ack};
      a_ack_q <= a_ack;
      if (a_load) a_valid <= 1'b1;
      else if (a_ack) a_valid <= 1'b0;  // destination has it so drop.
    end
  end

  always_ff @(posedge clka) begin
    if (a_load) a_data <= dataa;
  end

  // a_data has been stable for the whole synchronizer delay here.
  assign b_take = xb_valid[DEPTH-1] & ~b_valid & ~b_ack;
  assign validb = b_valid;
  assign datab  = b_data;

  always_ff @(posedge clkb or negedge rst_n) begin
    if (!rst_n) begin
      xb_valid <= '0;
      b_valid  <= 1'b0;
      b_ack    <= 1'b0;
    end else begin
      xb_valid <= {xb_valid[DEPTH-2:0], a_valid};
      if (b_valid && readyb) begin
        b_valid <= 1'b0;  // taken once.
        b_ack   <= 1'b1;
      end else if (b_take) begin
        b_valid <= 1'b1;
      end else if (!xb_valid[DEPTH-1]) begin
        b_ack   <= 1'b0;  // source valid fell so re-arm.
      end
    end
  end

  always_ff @(posedge clkb) begin
    if (b_take) b_data <= a_data;
  end

  // the source keeps its word until the crossing answers.
  a_data_hold: assert property (@(posedge clka) disable iff (!rst_n)
    (valida && !readya) |=> (!valida || $stable(dataa)));

endmodule

//--- hdl/xdom_pkg.sv
package xdom_pkg;

  localparam int ADDR_W = 4;   // 16 registers.
  localparam int DATA_W = 16;  // register and response width.
  localparam int CMD_W  = 24;  // command word width.
  localparam int NPORT  = 2;   // host and debug requesters.

  // one opcode bit picks how the rest of the word is read.
  typedef enum logic {
    OP_WRITE  = 1'b0,  // replace the whole register.
    OP_SETCLR = 1'b1   // clear then set bits of the low byte.
  } op_e;

  // full write view.
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        rsvd;  // must be zero.
    logic [DATA_W-1:0] data;
  } cmd_wr_t;

  // set/clear view. both masks zero reads the register back.
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        rsvd;
    logic [7:0]        set_mask;
    logic [7:0]        clr_mask;
  } cmd_sc_t;

  // op, addr and rsvd sit at the same bits in both views.
  typedef union packed {
    cmd_wr_t wr;
    cmd_sc_t sc;
  } cmd_word_u;

endpackage
